//--- build.f
+incdir+tb
verilog/alu_pkg.sv
verilog/idbs_decode.sv
verilog/alu_execute.sv
verilog/idb_result_mux.sv
verilog/alu_outmux_top.sv
tb/alu_outmux_tb.sv

//--- tb/alu_outmux_model.svh
// ==========================================================
// ALU output mux reference model
// expected A, F, ARG and BARG after one edge, and the idb
// value for a source code, built from the source table
// ==========================================================

`ifndef ALU_OUTMUX_MODEL_SVH
`define ALU_OUTMUX_MODEL_SVH

// register state after one aluclk edge
function automatic alu_regs_t alu_ref(
  input alu_regs_t   regs,
  input alu_op_e     op,
  input logic [15:0] a_in,
  input logic [15:0] b_in,
  input logic        ld_arg,
  input logic        ld_barg
);
  alu_regs_t   nxt;
  logic [16:0] wide;
  nxt = regs;
  // nop leaves A and F alone
  if (op != ALU_NOP) begin
    nxt.a = a_in;
    case (op)
      ALU_ADD: begin
        // carry out dropped
        wide  = {1'b0, a_in} + {1'b0, b_in};
        nxt.f = wide[15:0];
      end
      ALU_SUB: begin
        // two's complement of b, borrow dropped
        wide  = {1'b0, a_in} + {1'b0, ~b_in} + 17'd1;
        nxt.f = wide[15:0];
      end
      ALU_AND:   nxt.f = a_in & b_in;
      ALU_OR:    nxt.f = a_in | b_in;
      ALU_XOR:   nxt.f = a_in ^ b_in;
      ALU_PASSA: nxt.f = a_in;
      default:   nxt.f = b_in;
    endcase
  end
  if (ld_arg) begin
    nxt.arg = a_in;
  end
  if (ld_barg) begin
    nxt.barg = b_in;
  end
  return nxt;
endfunction

// idb for a registered code, phase and register set
function automatic logic [15:0] idb_ref(
  input logic [4:0] code,
  input logic       d2,
  input alu_regs_t  regs,
  input ext_src_t   ext
);
  case (code)
    IDBS_ALU:   return d2 ? regs.a : regs.f;
    IDBS_BMG:   return ext.bmg;
    IDBS_GPRH:  return {8'h00, ext.gpr[15:8]};
    IDBS_DBR:   return ext.dbr;
    IDBS_ARG:   return regs.arg;
    IDBS_STS:   return {8'h00, ext.sts};
    IDBS_BARG:  return regs.barg;
    IDBS_SWAP:  return {regs.f[7:0], regs.f[15:8]};
    IDBS_GPRL:  return {8'h00, ext.gpr[7:0]};
    IDBS_GPRS:  return {{8{ext.gpr[7]}}, ext.gpr[7:0]};
    IDBS_AARG:  return {regs.arg[15:8], regs.a[7:0]};
    IDBS_ABARG: return {regs.arg[15:8], regs.barg[7:0]};
    // unused codes leave the bus at zero
    default:    return 16'h0000;
  endcase
endfunction

`endif

//--- tb/alu_outmux_tb.sv
// ==========================================================
// ALU output mux testbench
// directed and random stimulus on the top level, a model
// of the ALU registers and a per cycle idb compare
// ==========================================================

module alu_outmux_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import alu_pkg::*;
  `include "alu_outmux_model.svh"

  localparam int reset_cycles  = 10;
  localparam int reset_timeout = 50;
  localparam int random_cycles = 3000;

  logic              aluclk;
  logic              arst_n;
  idbs_e             csidbs;
  logic              alu_d2;
  alu_op_e           alu_op;
  logic [word_w-1:0] opnd_a;
  logic [word_w-1:0] opnd_b;
  logic              load_arg;
  logic              load_barg;
  ext_src_t          ext_src;
  logic [word_w-1:0] idb;

  // model state, as seen after the last edge
  alu_regs_t   model_regs = '0;
  logic [4:0]  model_code = 5'd31;
  logic        model_d2   = 1'b0;

  // code groups for the directed parts
  logic [4:0] ext_codes [6] = '{IDBS_BMG, IDBS_DBR, IDBS_GPRH, IDBS_GPRL, IDBS_GPRS, IDBS_STS};
  logic [4:0] arg_codes [5] = '{IDBS_ARG, IDBS_BARG, IDBS_AARG, IDBS_ABARG, IDBS_SWAP};

  alu_outmux_top #(
    .data_width (word_w)
  ) u_alu_outmux_top (
    .aluclk    (aluclk),
    .arst_n    (arst_n),
    .csidbs    (csidbs),
    .alu_d2    (alu_d2),
    .alu_op    (alu_op),
    .opnd_a    (opnd_a),
    .opnd_b    (opnd_b),
    .load_arg  (load_arg),
    .load_barg (load_barg),
    .ext_src   (ext_src),
    .idb       (idb)
  );

  // 40 ns period
  always #20 aluclk = ~aluclk;

  // model follows the inputs sampled at each edge
  always @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      model_regs = '0;
      model_code = 5'd31;
      model_d2   = 1'b0;
    end else begin
      model_regs = alu_ref(model_regs, alu_op, opnd_a, opnd_b, load_arg, load_barg);
      model_code = csidbs;
      model_d2   = alu_d2;
    end
  end

  // idb is settled mid cycle, ext_src is taken as it is now
  initial begin : compare_idb
    logic [word_w-1:0] exp_idb;
    // first falling edge after the clock is running
    @(posedge aluclk);
    forever begin
      @(negedge aluclk);
      exp_idb = idb_ref(model_code, model_d2, model_regs, ext_src);
      assert (idb === exp_idb) else begin
        $display("Error: time %0t signal idb expected %h got %h", $time, exp_idb, idb);
        $display("Verification failed");
        $fatal(1, "idb mismatch");
      end
    end
  end

  function automatic logic rand_bit();
    return $urandom_range(0, 1) == 1;
  endfunction

  function automatic alu_op_e rand_op();
    return alu_op_e'($urandom_range(0, 7));
  endfunction

  function automatic ext_src_t rand_ext();
    ext_src_t ext_val;
    ext_val.bmg = word_w'($urandom());
    ext_val.dbr = word_w'($urandom());
    ext_val.gpr = word_w'($urandom());
    ext_val.sts = 8'($urandom());
    return ext_val;
  endfunction

  // one cycle of inputs, operands random
  task automatic drive_cycle(input logic [4:0] code, input logic d2, input alu_op_e op,
                             input logic la, input logic lb, input ext_src_t ext);
    @(posedge aluclk);
    csidbs    <= idbs_e'(code);
    alu_d2    <= d2;
    alu_op    <= op;
    opnd_a    <= word_w'($urandom());
    opnd_b    <= word_w'($urandom());
    load_arg  <= la;
    load_barg <= lb;
    ext_src   <= ext;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1) begin
      @(negedge aluclk);
      cycles = cycles + 1;
      if (cycles > reset_timeout) begin
        $display("reset release not seen within %0d cycles", reset_timeout);
        $display("Verification failed");
        $fatal(1, "reset timeout");
      end
    end
  endtask

  initial begin
    ext_src_t ext_val;
    int       i;
    int       v;
    void'($urandom(17));
    aluclk    = 1'b0;
    arst_n    = 1'b0;
    csidbs    = IDBS_ALU;
    alu_d2    = 1'b0;
    alu_op    = ALU_NOP;
    opnd_a    = '0;
    opnd_b    = '0;
    load_arg  = 1'b0;
    load_barg = 1'b0;
    ext_src   = '0;
    repeat (reset_cycles) @(posedge aluclk);
    arst_n <= 1'b1;
    wait_reset_release();
    // idle select right after reset, idb must stay zero
    drive_cycle(5'd31, 1'b0, ALU_NOP, 1'b0, 1'b0, rand_ext());
    // external sources
    for (i = 0; i < 6; i++) begin
      repeat (8) drive_cycle(ext_codes[i], rand_bit(), ALU_NOP, 1'b0, 1'b0, rand_ext());
    end
    // sign extension on both sides of 128
    for (v = 0; v < 256; v = v + 17) begin
      ext_val         = rand_ext();
      ext_val.gpr[7:0] = v[7:0];
      drive_cycle(IDBS_GPRS, rand_bit(), ALU_NOP, 1'b0, 1'b0, ext_val);
    end
    // A and F on both phases, nop holds the previous values
    for (i = 0; i < 8; i++) begin
      repeat (4) begin
        drive_cycle(IDBS_ALU, 1'b1, alu_op_e'(i), 1'b0, 1'b0, rand_ext());
        drive_cycle(IDBS_ALU, 1'b0, alu_op_e'(i), 1'b0, 1'b0, rand_ext());
      end
    end
    // argument registers and byte merges
    repeat (12) begin
      drive_cycle(IDBS_ALU, 1'b0, ALU_PASSA, rand_bit(), rand_bit(), rand_ext());
      for (i = 0; i < 5; i++) begin
        drive_cycle(arg_codes[i], rand_bit(), rand_op(), rand_bit(), rand_bit(), rand_ext());
      end
    end
    // unused codes
    repeat (2) begin
      drive_cycle(5'd5, rand_bit(), rand_op(), rand_bit(), rand_bit(), rand_ext());
      drive_cycle(5'd7, rand_bit(), rand_op(), rand_bit(), rand_bit(), rand_ext());
      for (i = 14; i < 32; i++) begin
        drive_cycle(5'(i), rand_bit(), rand_op(), rand_bit(), rand_bit(), rand_ext());
      end
    end
    // random mix of everything
    repeat (random_cycles) begin
      drive_cycle(5'($urandom_range(0, 31)), rand_bit(), rand_op(), rand_bit(), rand_bit(),
                  rand_ext());
    end
    drive_cycle(5'd31, 1'b0, ALU_NOP, 1'b0, 1'b0, rand_ext());
    // one cycle latency, two edges cover the last select
    repeat (2) @(posedge aluclk);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- verilog/alu_execute.sv
// ==========================================================
// ALU execute
// function unit with the A latch, the F result register
// and the ARG and BARG argument registers
// ==========================================================

module alu_execute #(
  parameter int data_width = alu_pkg::word_w
) (
  input  logic                  aluclk,
  input  logic                  arst_n,
  input  alu_pkg::alu_op_e      alu_op,
  input  logic [data_width-1:0] opnd_a,
  input  logic [data_width-1:0] opnd_b,
  input  logic                  load_arg,
  input  logic                  load_barg,
  output alu_pkg::alu_regs_t    alu_regs
);

  import alu_pkg::*;

  // A latch and F result
  logic [data_width-1:0] a_q;
  logic [data_width-1:0] f_q;
  // argument registers
  logic [data_width-1:0] arg_q;
  logic [data_width-1:0] barg_q;
  // function output before F
  logic [data_width-1:0] alu_f;

  always_comb begin
    case (alu_op)
      // add and sub wrap at the word size
      ALU_ADD:   alu_f = opnd_a + opnd_b;
      ALU_SUB:   alu_f = opnd_a - opnd_b;
      ALU_AND:   alu_f = opnd_a & opnd_b;
      ALU_OR:    alu_f = opnd_a | opnd_b;
      ALU_XOR:   alu_f = opnd_a ^ opnd_b;
      ALU_PASSA: alu_f = opnd_a;
      ALU_PASSB: alu_f = opnd_b;
      // nop, F keeps its value
      default:   alu_f = f_q;
    endcase
  end

  // A and F load together on any real op
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
      f_q <= '0;
    end else if (alu_op != ALU_NOP) begin
      a_q <= opnd_a;
      f_q <= alu_f;
    end
  end

  // ARG takes the A operand
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      arg_q <= '0;
    end else if (load_arg) begin
      arg_q <= opnd_a;
    end
  end

  // BARG takes the B operand
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      barg_q <= '0;
    end else if (load_barg) begin
      barg_q <= opnd_b;
    end
  end

  // bundle for the result mux
  assign alu_regs.a    = a_q;
  assign alu_regs.f    = f_q;
  assign alu_regs.arg  = arg_q;
  assign alu_regs.barg = barg_q;

  // microcode must present a defined op once out of reset
  a_alu_op_known : assert property (
    @(posedge aluclk) disable iff (!arst_n)
    !$isunknown(alu_op)
  );

  // byte lanes downstream are fixed at 8 bits
  a_data_width_word : assert property (
    @(posedge aluclk) disable iff (!arst_n)
    data_width == word_w
  );

endmodule

//--- verilog/alu_outmux_top.sv
// ==========================================================
// ALU output mux top
// source decode, execute registers and the idb result
// mux; idb follows the select by one aluclk cycle
// ==========================================================

module alu_outmux_top #(
  parameter int data_width = alu_pkg::word_w
) (
  input  logic                       aluclk,
  input  logic                       arst_n,
  input  alu_pkg::idbs_e             csidbs,
  input  logic                       alu_d2,
  input  alu_pkg::alu_op_e           alu_op,
  input  logic [data_width-1:0]      opnd_a,
  input  logic [data_width-1:0]      opnd_b,
  input  logic                       load_arg,
  input  logic                       load_barg,
  input  alu_pkg::ext_src_t          ext_src,
  output logic [alu_pkg::word_w-1:0] idb
);

  import alu_pkg::*;

  // registered source enables
  idb_en_t   idb_en;
  // A, F, ARG and BARG
  alu_regs_t alu_regs;

  // csidbs field to one-hot strobes
  idbs_decode u_idbs_decode (
    .aluclk (aluclk),
    .arst_n (arst_n),
    .csidbs (csidbs),
    .alu_d2 (alu_d2),
    .idb_en (idb_en)
  );

  // function unit and argument registers
  alu_execute #(
    .data_width (data_width)
  ) u_alu_execute (
    .aluclk    (aluclk),
    .arst_n    (arst_n),
    .alu_op    (alu_op),
    .opnd_a    (opnd_a),
    .opnd_b    (opnd_b),
    .load_arg  (load_arg),
    .load_barg (load_barg),
    .alu_regs  (alu_regs)
  );

  // external sources go straight to the mux
  idb_result_mux u_idb_result_mux (
    .idb_en   (idb_en),
    .alu_regs (alu_regs),
    .ext_src  (ext_src),
    .idb      (idb)
  );

endmodule

//--- verilog/alu_pkg.sv
// ==========================================================
// alu package
// shared types for the ALU output mux of the gate array:
// idb source codes, ALU ops, enable word, ALU register
// bundle and external bus sources
// ==========================================================

package alu_pkg;

  // native word of the machine, default for data_width
  localparam int word_w = 16;
  // byte lanes are fixed, so only a 16 bit word is legal
  localparam int byte_w = 8;

  // csidbs microcode field, source for idb in the next cycle
  typedef enum logic [4:0] {
    // A latch on alu_d2 high, F result on alu_d2 low
    IDBS_ALU   = 5'd0,
    // bit merge unit
    IDBS_BMG   = 5'd1,
    // high byte of the selected register
    IDBS_GPRH  = 5'd2,
    // data buffer register
    IDBS_DBR   = 5'd3,
    IDBS_ARG   = 5'd4,
    // status byte, zero extended
    IDBS_STS   = 5'd6,
    IDBS_BARG  = 5'd8,
    // F with bytes exchanged
    IDBS_SWAP  = 5'd9,
    // low byte of the selected register
    IDBS_GPRL  = 5'd10,
    // low byte sign extended
    IDBS_GPRS  = 5'd11,
    // ARG high byte over A low byte
    IDBS_AARG  = 5'd12,
    // ARG high byte over BARG low byte
    IDBS_ABARG = 5'd13
  } idbs_e;
  // codes 5, 7 and 14 to 31 select nothing and leave idb at zero

  // ALU function select
  typedef enum logic [2:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASSA,
    ALU_PASSB
  } alu_op_e;

  // registered idb enables, zero or one-hot
  typedef struct packed {
    logic ea;
    logic ef;
    logic eaarg;
    logic eabarg;
    logic earg;
    logic ebarg;
    logic ebmg;
    logic edbr;
    logic egprh;
    logic egprl;
    logic egprs;
    logic ests;
    logic eswap;
  } idb_en_t;

  // ALU side registers seen by the result mux
  typedef struct packed {
    logic [word_w-1:0] a;
    logic [word_w-1:0] f;
    logic [word_w-1:0] arg;
    logic [word_w-1:0] barg;
  } alu_regs_t;

  // sources from outside the ALU
  typedef struct packed {
    logic [word_w-1:0] bmg;
    logic [word_w-1:0] dbr;
    logic [word_w-1:0] gpr;
    logic [byte_w-1:0] sts;
  } ext_src_t;

endpackage

//--- verilog/idb_result_mux.sv
// ==========================================================
// idb result mux
// builds the swapped, merged, byte selected and sign
// extended values and gates the enabled one onto idb
// ==========================================================

module idb_result_mux (
  input  alu_pkg::idb_en_t           idb_en,
  input  alu_pkg::alu_regs_t         alu_regs,
  input  alu_pkg::ext_src_t          ext_src,
  output logic [alu_pkg::word_w-1:0] idb
);

  import alu_pkg::*;

  // derived bus values
  logic [word_w-1:0] swap_val;
  logic [word_w-1:0] aarg_val;
  logic [word_w-1:0] abarg_val;
  logic [word_w-1:0] gprh_val;
  logic [word_w-1:0] gprl_val;
  logic [word_w-1:0] gprs_val;
  logic [word_w-1:0] sts_val;

  // F with high and low bytes exchanged
  assign swap_val = {alu_regs.f[byte_w-1:0], alu_regs.f[word_w-1:byte_w]};

  // ARG high byte kept, low byte from A or BARG
  assign aarg_val  = {alu_regs.arg[word_w-1:byte_w], alu_regs.a[byte_w-1:0]};
  assign abarg_val = {alu_regs.arg[word_w-1:byte_w], alu_regs.barg[byte_w-1:0]};

  // register bytes land in the low lane
  assign gprh_val = {{byte_w{1'b0}}, ext_src.gpr[word_w-1:byte_w]};
  assign gprl_val = {{byte_w{1'b0}}, ext_src.gpr[byte_w-1:0]};

  // bit 7 copied across the high byte
  assign gprs_val = {{byte_w{ext_src.gpr[byte_w-1]}}, ext_src.gpr[byte_w-1:0]};

  // status is a byte wide
  assign sts_val = {{byte_w{1'b0}}, ext_src.sts};

  // and-or gating as on the array, zero when nothing enabled
  always_comb begin
    idb = ({word_w{idb_en.ea}}     & alu_regs.a)
        | ({word_w{idb_en.ef}}     & alu_regs.f)
        | ({word_w{idb_en.earg}}   & alu_regs.arg)
        | ({word_w{idb_en.ebarg}}  & alu_regs.barg)
        | ({word_w{idb_en.eaarg}}  & aarg_val)
        | ({word_w{idb_en.eabarg}} & abarg_val)
        | ({word_w{idb_en.ebmg}}   & ext_src.bmg)
        | ({word_w{idb_en.edbr}}   & ext_src.dbr)
        | ({word_w{idb_en.egprh}}  & gprh_val)
        | ({word_w{idb_en.egprl}}  & gprl_val)
        | ({word_w{idb_en.egprs}}  & gprs_val)
        | ({word_w{idb_en.ests}}   & sts_val)
        | ({word_w{idb_en.eswap}}  & swap_val);
  end

endmodule

//--- verilog/idbs_decode.sv
// ==========================================================
// idb source decode
// turns the csidbs microcode field and the alu_d2 phase
// into one registered one-hot enable per idb source
// ==========================================================

module idbs_decode (
  input  logic            aluclk,
  input  logic            arst_n,
  input  alu_pkg::idbs_e  csidbs,
  input  logic            alu_d2,
  output alu_pkg::idb_en_t idb_en
);

  import alu_pkg::*;

  // next enable word, before the register
  idb_en_t en_d;

  always_comb begin
    en_d = '0;
    case (csidbs)
      IDBS_ALU: begin
        // phase picks A latch or F result
        if (alu_d2) begin
          en_d.ea = 1'b1;
        end else begin
          en_d.ef = 1'b1;
        end
      end
      IDBS_BMG: begin
        en_d.ebmg = 1'b1;
      end
      IDBS_GPRH: begin
        en_d.egprh = 1'b1;
      end
      IDBS_DBR: begin
        en_d.edbr = 1'b1;
      end
      IDBS_ARG: begin
        en_d.earg = 1'b1;
      end
      IDBS_STS: begin
        en_d.ests = 1'b1;
      end
      IDBS_BARG: begin
        en_d.ebarg = 1'b1;
      end
      IDBS_SWAP: begin
        en_d.eswap = 1'b1;
      end
      IDBS_GPRL: begin
        en_d.egprl = 1'b1;
      end
      IDBS_GPRS: begin
        en_d.egprs = 1'b1;
      end
      IDBS_AARG: begin
        en_d.eaarg = 1'b1;
      end
      IDBS_ABARG: begin
        en_d.eabarg = 1'b1;
      end
      default: begin
        // unused code, bus stays at zero
        en_d = '0;
      end
    endcase
  end

  // strobes hold for one full aluclk cycle
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      idb_en <= '0;
    end else begin
      idb_en <= en_d;
    end
  end

  // never two sources on idb at once
  a_idb_en_onehot0 : assert property (
    @(posedge aluclk) disable iff (!arst_n)
    $onehot0(idb_en)
  );

endmodule
